/* Bender.yml */
package:
  name: uart_apb

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_pkg.sv
      - verilog/uart_fifo.sv
      - verilog/uart_baud_gen.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/uart_regs.sv
      - verilog/uart_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/uart_clk_gen.sv
      - bench/uart_checker.sv
      - bench/uart_tb.sv

/* bench/uart_checker.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_checker import uart_pkg::*; (
  input logic pclk_i,
  input logic txd_i
);

  int    err_cnt = 0;
  int    test_errs = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string test_name = "";

  function automatic logic [7:0] word_mask(input logic [7:0] lcr);
    word_mask = 8'((9'd1 << (5 + lcr[1:0])) - 9'd1);
  endfunction

  // Parity bit as the line should carry it
  function automatic logic expected_parity(input logic [7:0] lcr, input logic [7:0] data);
    logic ones;
    ones = ^(data & word_mask(lcr));
    case (parity_e'(lcr[5:4]))
      PAR_ODD:  expected_parity = ~ones;
      PAR_EVEN: expected_parity = ones;
      PAR_MARK: expected_parity = 1'b1;
      default:  expected_parity = 1'b0;
    endcase
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("%0t: test %s ok", $time, test_name);
    end else begin
      tests_failed++;
      $display("%0t: test %s failed with %0d errors", $time, test_name, test_errs);
    end
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      test_errs++;
      $display("[ERROR] %0t: %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string msg);
    err_cnt++;
    test_errs++;
    $display("%0t: timeout, %s", $time, msg);
  endtask

  // ==================================================
  // TX frame decoder, samples at mid-bit
  // ==================================================
  task automatic check_frame(input logic [7:0] lcr, input logic [15:0] div,
                             input logic [7:0] data);
    int         bit_cyc;
    int         cnt;
    int         i;
    logic [7:0] got;
    bit_cyc = `UART_OVERSAMPLE * div;
    got = '0;
    cnt = 0;
    while (txd_i !== 1'b0 && cnt < 1000) begin
      @(negedge pclk_i);
      cnt++;
    end
    if (txd_i !== 1'b0) begin
      report_timeout("no start bit appeared on txd_o");
      return;
    end
    repeat (bit_cyc / 2) @(negedge pclk_i);
    check_eq("tx start bit", txd_i, 1'b0);
    for (i = 0; i < 5 + lcr[1:0]; i++) begin
      repeat (bit_cyc) @(negedge pclk_i);
      got[i] = txd_i;
    end
    check_eq("tx data", got, data & word_mask(lcr));
    if (lcr[3]) begin
      repeat (bit_cyc) @(negedge pclk_i);
      check_eq("tx parity bit", txd_i, expected_parity(lcr, data));
    end
    for (i = 0; i < (lcr[2] ? 2 : 1); i++) begin
      repeat (bit_cyc) @(negedge pclk_i);
      check_eq("tx stop bit", txd_i, 1'b1);
    end
  endtask

  task automatic print_summary();
    $display("summary: %0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_failed, err_cnt);
  endtask

endmodule

/* bench/uart_clk_gen.sv */
`timescale 1ns/10ps

module uart_clk_gen (
  output logic pclk_o,
  output logic prstn_o
);

  // 10 ns period
  initial begin
    pclk_o = 1'b0;
    forever #5 pclk_o = ~pclk_o;
  end

  initial begin
    prstn_o = 1'b0;
    repeat (5) @(posedge pclk_o);
    prstn_o <= 1'b1;
  end

endmodule

/* bench/uart_tb.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_tb import uart_pkg::*; ();

  typedef enum logic {K_TX, K_RX} kind_e;

  typedef struct packed {
    kind_e       kind;
    logic [7:0]  lcr;
    logic [15:0] div;
    logic [7:0]  data;
    logic        bad_par;
  } row_t;

  logic        pclk;
  logic        prstn;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        rxd;
  logic        txd;
  logic        irq;
  row_t        rows[$];
  logic [7:0]  lb_data[`UART_FIFO_DEPTH];

  uart_clk_gen i_clk_gen (.pclk_o(pclk), .prstn_o(prstn));

  uart_top i_uart_top (
    .pclk_i(pclk), .prstn_i(prstn), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .rxd_i(rxd),
    .prdata_o(prdata), .pready_o(pready), .txd_o(txd), .irq_o(irq)
  );

  uart_checker i_checker (.pclk_i(pclk), .txd_i(txd));

  function automatic logic [7:0] make_lcr(input int bits, input logic two_stop,
                                          input logic par_en, input parity_e mode);
    make_lcr = {2'b00, mode, par_en, two_stop, 2'(bits - 5)};
  endfunction

  task automatic add_row(input kind_e k, input logic [7:0] lcr, input logic [15:0] div,
                         input logic bad);
    row_t row;
    row = '{k, lcr, div, 8'($urandom), bad};
    rows.push_back(row);
  endtask

  // ==================================================
  // APB master
  // ==================================================
  task automatic reg_write(input reg_addr_e r, input logic [7:0] d);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= {r, 2'b00};
    pwdata  <= {24'h0, d};
    @(posedge pclk);
    penable <= 1'b1;
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic reg_read(input reg_addr_e r, output logic [31:0] d);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= {r, 2'b00};
    @(posedge pclk);
    penable <= 1'b1;
    @(negedge pclk);
    d = prdata;
    i_checker.check_eq("pready", pready, 1'b1);
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic set_line(input logic [7:0] lcr, input logic [15:0] div);
    reg_write(REG_LCR, lcr | 8'h80);
    reg_write(REG_DATA, div[7:0]);
    reg_write(REG_IER, div[15:8]);
    reg_write(REG_LCR, lcr);
  endtask

  task automatic wait_lsr(input logic [7:0] mask, output logic [31:0] lsr);
    int cnt;
    cnt = 0;
    lsr = '0;
    while (cnt < 4000) begin
      reg_read(REG_LSR, lsr);
      if ((lsr[7:0] & mask) == mask) break;
      cnt++;
    end
    if ((lsr[7:0] & mask) != mask) begin
      i_checker.report_timeout($sformatf("LSR bits %0h never set", mask));
    end
  endtask

  task automatic wait_irq();
    int cnt;
    cnt = 0;
    while (irq !== 1'b1 && cnt < 5000) begin
      @(negedge pclk);
      cnt++;
    end
    if (irq !== 1'b1) i_checker.report_timeout("irq_o never rose");
  endtask

  task automatic check_irq(input logic exp);
    @(negedge pclk);
    i_checker.check_eq("irq_o", irq, exp);
  endtask

  // ==================================================
  // Serial driver on rxd_i
  // ==================================================
  task automatic drive_bit(input logic b, input int cyc);
    @(posedge pclk);
    rxd <= b;
    repeat (cyc - 1) @(posedge pclk);
  endtask

  task automatic send_frame(input logic [7:0] lcr, input logic [15:0] div, input logic [7:0] data,
                            input logic bad_par, input logic bad_stop);
    int bit_cyc;
    int i;
    bit_cyc = `UART_OVERSAMPLE * div;
    drive_bit(1'b0, bit_cyc);
    for (i = 0; i < 5 + lcr[1:0]; i++) drive_bit(data[i], bit_cyc);
    if (lcr[3]) drive_bit(i_checker.expected_parity(lcr, data) ^ bad_par, bit_cyc);
    drive_bit(~bad_stop, bit_cyc);
    if (lcr[2]) drive_bit(1'b1, bit_cyc);
    // One idle bit between frames
    drive_bit(1'b1, bit_cyc);
  endtask

  initial begin
    int          seed;
    int          cnt;
    int          i;
    logic [7:0]  lcr;
    logic [31:0] v;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rxd     = 1'b1;
    seed = 19905;
    void'($urandom(seed));

    add_row(K_TX, make_lcr(5, 0, 0, PAR_ODD), 16'd2, 1'b0);
    add_row(K_TX, make_lcr(6, 0, 1, PAR_ODD), 16'd2, 1'b0);
    add_row(K_TX, make_lcr(7, 1, 1, PAR_EVEN), 16'd3, 1'b0);
    add_row(K_TX, make_lcr(8, 0, 1, PAR_MARK), 16'd2, 1'b0);
    add_row(K_TX, make_lcr(8, 1, 1, PAR_SPACE), 16'd1, 1'b0);
    add_row(K_RX, make_lcr(8, 0, 0, PAR_ODD), 16'd2, 1'b0);
    add_row(K_RX, make_lcr(5, 0, 1, PAR_EVEN), 16'd2, 1'b0);
    add_row(K_RX, make_lcr(7, 1, 1, PAR_ODD), 16'd3, 1'b0);
    add_row(K_RX, make_lcr(6, 0, 1, PAR_MARK), 16'd2, 1'b0);
    add_row(K_RX, make_lcr(8, 0, 1, PAR_SPACE), 16'd2, 1'b1);
    add_row(K_RX, make_lcr(8, 0, 1, PAR_EVEN), 16'd1, 1'b1);

    cnt = 0;
    while (prstn !== 1'b1 && cnt < 100) begin
      @(posedge pclk);
      cnt++;
    end
    if (prstn !== 1'b1) i_checker.report_timeout("reset was never released");

    i_checker.start_test("registers after reset");
    @(negedge pclk);
    i_checker.check_eq("txd_o", txd, 1'b1);
    i_checker.check_eq("irq_o", irq, 1'b0);
    i_checker.check_eq("prdata_o", prdata, 32'h0);
    reg_read(REG_LCR, v);
    i_checker.check_eq("LCR", v, 32'h0);
    reg_read(REG_IER, v);
    i_checker.check_eq("IER", v, 32'h0);
    reg_read(REG_LSR, v);
    i_checker.check_eq("LSR", v, 32'h60);
    reg_read(REG_IIR, v);
    i_checker.check_eq("IIR", v, 32'hc3);
    i_checker.end_test();

    i_checker.start_test("register read back");
    reg_write(REG_LCR, 8'h1b);
    reg_read(REG_LCR, v);
    i_checker.check_eq("LCR", v, 32'h1b);
    reg_write(REG_IER, 8'h07);
    reg_read(REG_IER, v);
    i_checker.check_eq("IER", v, 32'h07);
    reg_write(REG_IER, 8'h00);
    reg_write(REG_CTRL, 8'h01);
    reg_read(REG_CTRL, v);
    i_checker.check_eq("CTRL", v, 32'h01);
    reg_write(REG_CTRL, 8'h00);
    reg_write(REG_LCR, 8'h83);
    reg_write(REG_DATA, 8'h34);
    reg_write(REG_IER, 8'h12);
    reg_read(REG_DATA, v);
    i_checker.check_eq("divisor low", v, 32'h34);
    reg_read(REG_IER, v);
    i_checker.check_eq("divisor high", v, 32'h12);
    reg_write(REG_LCR, 8'h03);
    reg_read(REG_IER, v);
    i_checker.check_eq("IER behind DLAB", v, 32'h00);
    i_checker.end_test();

    for (int r = 0; r < rows.size(); r++) begin
      i_checker.start_test($sformatf("%s row %0d", rows[r].kind == K_TX ? "tx" : "rx", r));
      set_line(rows[r].lcr, rows[r].div);
      if (rows[r].kind == K_TX) begin
        reg_write(REG_DATA, rows[r].data);
        i_checker.check_frame(rows[r].lcr, rows[r].div, rows[r].data);
        wait_lsr(8'h40, v);
      end else begin
        send_frame(rows[r].lcr, rows[r].div, rows[r].data, rows[r].bad_par, 1'b0);
        wait_lsr(8'h01, v);
        i_checker.check_eq("LSR parity error", v[2], rows[r].bad_par);
        i_checker.check_eq("LSR framing error", v[3], 1'b0);
        reg_read(REG_DATA, v);
        i_checker.check_eq("rx data", v, rows[r].data & i_checker.word_mask(rows[r].lcr));
        reg_read(REG_LSR, v);
        i_checker.check_eq("LSR after read", v[3:0], 4'h0);
      end
      i_checker.end_test();
    end

    // Parity error, framing error, then enough frames to overflow
    i_checker.start_test("line errors");
    lcr = make_lcr(8, 0, 1, PAR_EVEN);
    set_line(lcr, 16'd2);
    send_frame(lcr, 16'd2, 8'ha5, 1'b1, 1'b0);
    send_frame(lcr, 16'd2, 8'h5a, 1'b0, 1'b1);
    repeat (`UART_FIFO_DEPTH - 1) send_frame(lcr, 16'd2, 8'($urandom), 1'b0, 1'b0);
    reg_read(REG_LSR, v);
    i_checker.check_eq("LSR with errors", v, 32'h6f);
    reg_read(REG_LSR, v);
    i_checker.check_eq("LSR after clear", v, 32'h61);
    reg_read(REG_DATA, v);
    i_checker.check_eq("oldest byte", v, 32'ha5);
    repeat (`UART_FIFO_DEPTH - 1) reg_read(REG_DATA, v);
    reg_read(REG_LSR, v);
    i_checker.check_eq("LSR drained", v, 32'h60);
    i_checker.end_test();

    i_checker.start_test("interrupts");
    check_irq(1'b0);
    reg_write(REG_IER, 8'h02);
    check_irq(1'b1);
    reg_read(REG_IIR, v);
    i_checker.check_eq("IIR tx idle", v, 32'hc3);
    reg_write(REG_IER, 8'h01);
    check_irq(1'b0);
    send_frame(lcr, 16'd2, 8'h3c, 1'b1, 1'b0);
    wait_irq();
    reg_read(REG_IIR, v);
    i_checker.check_eq("IIR tx idle over data ready", v, 32'hc3);
    reg_read(REG_DATA, v);
    i_checker.check_eq("rx data", v, 32'h3c);
    check_irq(1'b0);
    reg_write(REG_IER, 8'h04);
    check_irq(1'b1);
    reg_write(REG_DATA, 8'h00);
    reg_read(REG_IIR, v);
    i_checker.check_eq("IIR line error", v, 32'hc7);
    reg_read(REG_LSR, v);
    check_irq(1'b0);
    wait_lsr(8'h40, v);
    i_checker.end_test();

    i_checker.start_test("loopback");
    set_line(make_lcr(8, 0, 0, PAR_ODD), 16'd2);
    reg_write(REG_CTRL, 8'h01);
    reg_write(REG_IER, 8'h01);
    // Held low so a missing mux would start frames
    @(posedge pclk);
    rxd <= 1'b0;
    for (i = 0; i < `UART_FIFO_DEPTH; i++) begin
      lb_data[i] = 8'($urandom);
      reg_write(REG_DATA, lb_data[i]);
    end
    wait_irq();
    reg_read(REG_IIR, v);
    i_checker.check_eq("IIR data ready", v, 32'hc5);
    wait_lsr(8'h40, v);
    for (i = 0; i < `UART_FIFO_DEPTH; i++) begin
      reg_read(REG_DATA, v);
      i_checker.check_eq($sformatf("loopback byte %0d", i), v, lb_data[i]);
    end
    reg_read(REG_LSR, v);
    i_checker.check_eq("data ready after drain", v[0], 1'b0);
    @(posedge pclk);
    rxd <= 1'b1;
    reg_write(REG_CTRL, 8'h00);
    reg_write(REG_IER, 8'h00);
    i_checker.end_test();

    i_checker.print_summary();
    if (i_checker.err_cnt == 0 && i_checker.tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_fifo.sv
verilog/uart_baud_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
bench/uart_clk_gen.sv
bench/uart_checker.sv
bench/uart_tb.sv

/* verilog/uart_baud_gen.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_baud_gen import uart_pkg::*; #(
  parameter int FIRST_TICKS = `UART_OVERSAMPLE
) (
  input  logic                   pclk_i,
  input  logic                   prstn_i,
  input  logic                   enable_i,
  input  logic [`UART_DIV_W-1:0] divisor_i,
  output logic                   bit_o
);

  localparam int TW = $clog2(`UART_OVERSAMPLE);
  localparam logic [TW-1:0] FIRST_LOAD = TW'(FIRST_TICKS - 1);
  localparam logic [TW-1:0] BIT_LOAD   = TW'(`UART_OVERSAMPLE - 1);

  logic [`UART_DIV_W-1:0] div_cnt;
  logic [TW-1:0]          tick_cnt;
  logic                   tick;

  // Zero divisor stalls the generator
  assign tick  = enable_i && (divisor_i != '0) && (div_cnt == divisor_i - 1'b1);
  assign bit_o = tick && (tick_cnt == '0);

  always_ff @(posedge pclk_i or negedge prstn_i) begin
    if (!prstn_i) begin
      div_cnt  <= '0;
      tick_cnt <= FIRST_LOAD;
    end else if (!enable_i) begin
      div_cnt  <= '0;
      tick_cnt <= FIRST_LOAD;
    end else if (tick) begin
      div_cnt  <= '0;
      tick_cnt <= (tick_cnt == '0) ? BIT_LOAD : tick_cnt - 1'b1;
    end else if (divisor_i != '0) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

/* verilog/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Character and FIFO sizes
`define UART_DATA_W      8
`define UART_FIFO_DEPTH  16

// Baud divider
`define UART_DIV_W       16
`define UART_OVERSAMPLE  16

// APB port widths
`define UART_APB_AW      8
`define UART_APB_DW      32

`endif

/* verilog/uart_fifo.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_fifo #(
  parameter int WIDTH = `UART_DATA_W,
  parameter int DEPTH = `UART_FIFO_DEPTH
) (
  input  logic             pclk_i,
  input  logic             prstn_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] wdata_i,
  input  logic             pop_i,
  input  logic             ovr_clr_i,
  output logic [WIDTH-1:0] rdata_o,
  output logic             empty_o,
  output logic             full_o,
  output logic             ovr_o
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  // Extra MSB tells full from empty
  logic [AW:0]      wr_ptr;
  logic [AW:0]      rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign empty_o = wr_ptr == rd_ptr;
  assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign rdata_o = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge pclk_i) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= wdata_i;
    end
  end

  always_ff @(posedge pclk_i or negedge prstn_i) begin
    if (!prstn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      ovr_o  <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      // New drop wins over clear
      ovr_o <= (ovr_o & ~ovr_clr_i) | (push_i & full_o);
    end
  end

endmodule

/* verilog/uart_pkg.sv */
`include "uart_consts.svh"

package uart_pkg;

  typedef enum logic [2:0] {
    TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP1, TX_STOP2
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
  } rx_state_e;

  // Word offsets, paddr[7:2]
  typedef enum logic [5:0] {
    REG_DATA = 6'd0,
    REG_IER  = 6'd1,
    REG_IIR  = 6'd2,
    REG_LCR  = 6'd3,
    REG_LSR  = 6'd5,
    REG_CTRL = 6'd8
  } reg_addr_e;

  typedef enum logic [1:0] {
    PAR_ODD, PAR_EVEN, PAR_MARK, PAR_SPACE
  } parity_e;

endpackage

/* verilog/uart_regs.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_regs import uart_pkg::*; (
  input  logic                    pclk_i,
  input  logic                    prstn_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`UART_APB_AW-1:0] paddr_i,
  input  logic [`UART_APB_DW-1:0] pwdata_i,
  input  logic [`UART_DATA_W-1:0] rx_data_i,
  input  logic                    rx_empty_i,
  input  logic                    rx_ovr_i,
  input  logic                    parity_err_i,
  input  logic                    framing_err_i,
  input  logic                    tx_busy_i,
  input  logic                    tx_empty_i,
  output logic [`UART_APB_DW-1:0] prdata_o,
  output logic                    pready_o,
  output logic                    tx_push_o,
  output logic [`UART_DATA_W-1:0] tx_data_o,
  output logic                    rx_pop_o,
  output logic                    lsr_read_o,
  output logic [`UART_DIV_W-1:0]  divisor_o,
  output logic [1:0]              word_len_o,
  output logic                    two_stop_o,
  output logic                    parity_en_o,
  output parity_e                 parity_mode_o,
  output logic                    loopback_o,
  output logic                    irq_o
);

  reg_addr_e addr;
  logic [7:0] lcr;
  logic [2:0] ier;
  logic       dlab;
  logic       wr_en;
  logic       rd_access;
  logic       src_rdy;
  logic       src_thr;
  logic       src_err;
  logic [2:0] int_id;
  logic [7:0] lsr;
  logic [7:0] iir;
  logic [7:0] rd_byte;

  assign addr      = reg_addr_e'(paddr_i[`UART_APB_AW-1:2]);
  assign dlab      = lcr[7];
  assign wr_en     = psel_i & penable_i & pwrite_i;
  assign rd_access = psel_i & penable_i & ~pwrite_i;
  assign pready_o  = 1'b1;

  assign tx_push_o  = wr_en & (addr == REG_DATA) & ~dlab;
  assign tx_data_o  = pwdata_i[`UART_DATA_W-1:0];
  assign rx_pop_o   = rd_access & (addr == REG_DATA) & ~dlab;
  assign lsr_read_o = rd_access & (addr == REG_LSR);

  assign word_len_o    = lcr[1:0];
  assign two_stop_o    = lcr[2];
  assign parity_en_o   = lcr[3];
  assign parity_mode_o = parity_e'(lcr[5:4]);

  // ==================================================
  // Status and interrupts
  // ==================================================
  assign src_rdy = ~rx_empty_i;
  assign src_thr = ~tx_busy_i;
  assign src_err = rx_ovr_i | parity_err_i | framing_err_i;
  assign int_id  = src_thr ? 3'd1 : src_rdy ? 3'd2 : src_err ? 3'd3 : 3'd0;
  assign lsr = {1'b0, src_thr & tx_empty_i, src_thr, 1'b0,
                framing_err_i, parity_err_i, rx_ovr_i, src_rdy};
  assign iir = {2'b11, 2'b00, int_id, src_thr | src_rdy | src_err};
  assign irq_o = |(ier & {src_err, src_thr, src_rdy});

  always_ff @(posedge pclk_i or negedge prstn_i) begin
    if (!prstn_i) begin
      lcr        <= '0;
      ier        <= '0;
      divisor_o  <= '0;
      loopback_o <= 1'b0;
    end else if (wr_en) begin
      case (addr)
        REG_DATA: if (dlab) divisor_o[7:0] <= pwdata_i[7:0];
        REG_IER: begin
          if (dlab) divisor_o[15:8] <= pwdata_i[7:0];
          else      ier             <= pwdata_i[2:0];
        end
        REG_LCR:  lcr        <= pwdata_i[7:0];
        REG_CTRL: loopback_o <= pwdata_i[0];
        default: ;
      endcase
    end
  end

  // ==================================================
  // Read data
  // ==================================================
  always_comb begin
    case (addr)
      REG_DATA: rd_byte = dlab ? divisor_o[7:0] : rx_data_i;
      REG_IER:  rd_byte = dlab ? divisor_o[15:8] : {5'b0, ier};
      REG_IIR:  rd_byte = iir;
      REG_LCR:  rd_byte = lcr;
      REG_LSR:  rd_byte = lsr;
      REG_CTRL: rd_byte = {7'b0, loopback_o};
      default:  rd_byte = '0;
    endcase
  end

  // Captured in setup, held through access
  always_ff @(posedge pclk_i or negedge prstn_i) begin
    if (!prstn_i) begin
      prdata_o <= '0;
    end else if (psel_i & ~penable_i & ~pwrite_i) begin
      prdata_o <= {{(`UART_APB_DW-8){1'b0}}, rd_byte};
    end else begin
      prdata_o <= '0;
    end
  end

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_rx import uart_pkg::*; (
  input  logic                    pclk_i,
  input  logic                    prstn_i,
  input  logic                    bit_i,
  input  logic                    rxd_i,
  input  logic [1:0]              word_len_i,
  input  logic                    parity_en_i,
  input  parity_e                 parity_mode_i,
  input  logic                    err_clr_i,
  output logic                    busy_o,
  output logic                    push_o,
  output logic [`UART_DATA_W-1:0] data_o,
  output logic                    parity_err_o,
  output logic                    framing_err_o
);

  rx_state_e  state;
  logic [1:0] rxd_sync;
  logic       rxd;
  logic [2:0] bit_idx;
  logic [2:0] last_idx;
  logic       par_rx;
  logic       par_exp;

  assign rxd      = rxd_sync[1];
  assign last_idx = 3'd4 + {1'b0, word_len_i};
  assign busy_o   = state != RX_IDLE;
  // Stop bit sampled
  assign push_o   = (state == RX_STOP) & bit_i;

  // High bits of data_o are cleared at start, so a plain XOR works
  always_comb begin
    case (parity_mode_i)
      PAR_ODD:  par_exp = ~(^data_o);
      PAR_EVEN: par_exp = ^data_o;
      PAR_MARK: par_exp = 1'b1;
      default:  par_exp = 1'b0;
    endcase
  end

  always_ff @(posedge pclk_i or negedge prstn_i) begin
    if (!prstn_i) begin
      rxd_sync      <= 2'b11;
      state         <= RX_IDLE;
      data_o        <= '0;
      bit_idx       <= '0;
      par_rx        <= 1'b0;
      parity_err_o  <= 1'b0;
      framing_err_o <= 1'b0;
    end else begin
      rxd_sync      <= {rxd_sync[0], rxd_i};
      parity_err_o  <= (parity_err_o & ~err_clr_i) |
                       (push_o & parity_en_i & (par_rx != par_exp));
      framing_err_o <= (framing_err_o & ~err_clr_i) | (push_o & ~rxd);
      case (state)
        RX_IDLE: if (!rxd) state <= RX_START;
        RX_START: if (bit_i) begin
          // Glitch if line is high again at mid start bit
          state   <= rxd ? RX_IDLE : RX_DATA;
          data_o  <= '0;
          bit_idx <= '0;
        end
        RX_DATA: if (bit_i) begin
          data_o[bit_idx] <= rxd;
          bit_idx         <= bit_idx + 1'b1;
          if (bit_idx == last_idx) state <= parity_en_i ? RX_PARITY : RX_STOP;
        end
        RX_PARITY: if (bit_i) begin
          par_rx <= rxd;
          state  <= RX_STOP;
        end
        RX_STOP: if (bit_i) state <= RX_IDLE;
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

/* verilog/uart_top.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_top import uart_pkg::*; (
  input  logic                    pclk_i,
  input  logic                    prstn_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`UART_APB_AW-1:0] paddr_i,
  input  logic [`UART_APB_DW-1:0] pwdata_i,
  input  logic                    rxd_i,
  output logic [`UART_APB_DW-1:0] prdata_o,
  output logic                    pready_o,
  output logic                    txd_o,
  output logic                    irq_o
);

  logic [`UART_DATA_W-1:0] tx_wdata;
  logic [`UART_DATA_W-1:0] tx_fifo_data;
  logic [`UART_DATA_W-1:0] rx_char;
  logic [`UART_DATA_W-1:0] rx_fifo_data;
  logic [`UART_DIV_W-1:0]  divisor;
  logic [1:0]              word_len;
  parity_e                 parity_mode;
  logic tx_push, tx_pop, tx_empty, tx_busy, tx_bit;
  logic rx_push, rx_pop, rx_empty, rx_ovr, rx_busy, rx_bit;
  logic parity_err, framing_err, lsr_read;
  logic two_stop, parity_en, loopback, rxd;

  // Loopback feeds the receiver from our own transmitter
  assign rxd = loopback ? txd_o : rxd_i;

  uart_regs i_regs (
    .pclk_i, .prstn_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .rx_data_i(rx_fifo_data), .rx_empty_i(rx_empty), .rx_ovr_i(rx_ovr),
    .parity_err_i(parity_err), .framing_err_i(framing_err),
    .tx_busy_i(tx_busy), .tx_empty_i(tx_empty),
    .prdata_o, .pready_o,
    .tx_push_o(tx_push), .tx_data_o(tx_wdata), .rx_pop_o(rx_pop),
    .lsr_read_o(lsr_read), .divisor_o(divisor), .word_len_o(word_len),
    .two_stop_o(two_stop), .parity_en_o(parity_en),
    .parity_mode_o(parity_mode), .loopback_o(loopback), .irq_o
  );

  uart_fifo i_tx_fifo (
    .pclk_i, .prstn_i, .push_i(tx_push), .wdata_i(tx_wdata), .pop_i(tx_pop),
    .ovr_clr_i(1'b0), .rdata_o(tx_fifo_data), .empty_o(tx_empty),
    .full_o(), .ovr_o()
  );

  uart_fifo i_rx_fifo (
    .pclk_i, .prstn_i, .push_i(rx_push), .wdata_i(rx_char), .pop_i(rx_pop),
    .ovr_clr_i(lsr_read), .rdata_o(rx_fifo_data), .empty_o(rx_empty),
    .full_o(), .ovr_o(rx_ovr)
  );

  uart_baud_gen #(.FIRST_TICKS(`UART_OVERSAMPLE)) i_tx_baud (
    .pclk_i, .prstn_i, .enable_i(tx_busy), .divisor_i(divisor), .bit_o(tx_bit)
  );

  // Half a bit first, so samples land mid-bit
  uart_baud_gen #(.FIRST_TICKS(`UART_OVERSAMPLE / 2)) i_rx_baud (
    .pclk_i, .prstn_i, .enable_i(rx_busy), .divisor_i(divisor), .bit_o(rx_bit)
  );

  uart_tx i_tx (
    .pclk_i, .prstn_i, .bit_i(tx_bit), .fifo_data_i(tx_fifo_data),
    .fifo_empty_i(tx_empty), .word_len_i(word_len), .two_stop_i(two_stop),
    .parity_en_i(parity_en), .parity_mode_i(parity_mode),
    .fifo_pop_o(tx_pop), .busy_o(tx_busy), .txd_o
  );

  uart_rx i_rx (
    .pclk_i, .prstn_i, .bit_i(rx_bit), .rxd_i(rxd), .word_len_i(word_len),
    .parity_en_i(parity_en), .parity_mode_i(parity_mode), .err_clr_i(lsr_read),
    .busy_o(rx_busy), .push_o(rx_push), .data_o(rx_char),
    .parity_err_o(parity_err), .framing_err_o(framing_err)
  );

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_tx import uart_pkg::*; (
  input  logic                    pclk_i,
  input  logic                    prstn_i,
  input  logic                    bit_i,
  input  logic [`UART_DATA_W-1:0] fifo_data_i,
  input  logic                    fifo_empty_i,
  input  logic [1:0]              word_len_i,
  input  logic                    two_stop_i,
  input  logic                    parity_en_i,
  input  parity_e                 parity_mode_i,
  output logic                    fifo_pop_o,
  output logic                    busy_o,
  output logic                    txd_o
);

  tx_state_e               state;
  logic [`UART_DATA_W-1:0] shift;
  logic [`UART_DATA_W-1:0] word_mask;
  logic [2:0]              bit_idx;
  logic [2:0]              last_idx;
  logic                    par_bit;
  logic                    par_next;
  logic                    data_xor;

  assign word_mask  = 8'hff >> (2'd3 - word_len_i);
  assign last_idx   = 3'd4 + {1'b0, word_len_i};
  assign data_xor   = ^(fifo_data_i & word_mask);
  assign fifo_pop_o = (state == TX_IDLE) & ~fifo_empty_i;
  assign busy_o     = state != TX_IDLE;

  always_comb begin
    case (parity_mode_i)
      PAR_ODD:  par_next = ~data_xor;
      PAR_EVEN: par_next = data_xor;
      PAR_MARK: par_next = 1'b1;
      default:  par_next = 1'b0;
    endcase
  end

  // ==================================================
  // Frame FSM
  // ==================================================
  always_ff @(posedge pclk_i or negedge prstn_i) begin
    if (!prstn_i) begin
      state   <= TX_IDLE;
      shift   <= '0;
      bit_idx <= '0;
      par_bit <= 1'b0;
      txd_o   <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: if (fifo_pop_o) begin
          shift   <= fifo_data_i;
          par_bit <= par_next;
          bit_idx <= '0;
          txd_o   <= 1'b0;
          state   <= TX_START;
        end
        TX_START: if (bit_i) begin
          txd_o <= shift[0];
          shift <= shift >> 1;
          state <= TX_DATA;
        end
        TX_DATA: if (bit_i) begin
          if (bit_idx == last_idx) begin
            txd_o <= parity_en_i ? par_bit : 1'b1;
            state <= parity_en_i ? TX_PARITY : TX_STOP1;
          end else begin
            txd_o   <= shift[0];
            shift   <= shift >> 1;
            bit_idx <= bit_idx + 1'b1;
          end
        end
        TX_PARITY: if (bit_i) begin
          txd_o <= 1'b1;
          state <= TX_STOP1;
        end
        TX_STOP1: if (bit_i) state <= two_stop_i ? TX_STOP2 : TX_IDLE;
        TX_STOP2: if (bit_i) state <= TX_IDLE;
        default: begin
          txd_o <= 1'b1;
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule
